//--- rtl/shmem_pkg.sv
package shmem_pkg;

	localparam int num_cores = 4;
	localparam int num_banks = 4;
	localparam int data_w = 16;
	localparam int word_w = 8; // word address inside one bank
	localparam int bank_w = 2;
	localparam int core_id_w = 2;
	localparam int addr_w = bank_w + word_w; // bank select sits on top

	localparam int bank_depth = 1 << word_w;
	localparam int mem_words = num_banks * bank_depth;

	typedef logic [data_w-1:0] data_t;
	typedef logic [word_w-1:0] word_addr_t;
	typedef logic [bank_w-1:0] bank_id_t;
	typedef logic [core_id_w-1:0] core_id_t;
	typedef logic [addr_w-1:0] addr_t;

	// core operation, held by the core until its ready bit
	typedef enum logic [1:0]
	{
		op_none = 2'b00,
		op_read = 2'b01,
		op_write = 2'b10
	} mem_op_e;

	typedef enum logic [1:0]
	{
		scan_idle,
		scan_run,
		scan_drain // last word still on its way out of the bank
	} scan_state_e;

	typedef struct packed
	{
		mem_op_e op;
		addr_t addr;
		data_t wdata;
	} core_req_t;

	typedef struct packed
	{
		logic rd;
		logic wr;
		word_addr_t addr;
		data_t wdata;
	} bank_cmd_t;

	// valid marks a bank read whose data comes back next cycle
	typedef struct packed
	{
		logic valid;
		logic is_scan;
		core_id_t core_id;
	} bank_grant_t;

	typedef struct packed
	{
		addr_t addr;
		data_t data;
	} scan_word_t;

endpackage

//--- rtl/rr_core_finder.sv
`timescale 1ns/1ps

module rr_core_finder
(
	input logic [shmem_pkg::num_cores-1:0] mask,
	input shmem_pkg::core_id_t last,
	output shmem_pkg::core_id_t next,
	output logic none
);

	// search starts one past last and wraps, last itself comes at the end
	always_comb
	begin
		shmem_pkg::core_id_t idx;
		next = last;
		none = 1'b1;
		for (int i = 1; i <= shmem_pkg::num_cores; i++)
		begin
			idx = last + shmem_pkg::core_id_t'(i);
			if (none && mask[idx])
			begin
				next = idx;
				none = 1'b0;
			end
		end
	end

endmodule

//--- rtl/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter
(
	input logic clk,
	input logic reset,
	input shmem_pkg::core_req_t req [shmem_pkg::num_cores],
	input logic scan_req_valid,
	input shmem_pkg::addr_t scan_req_addr,
	output shmem_pkg::bank_cmd_t bank_cmd [shmem_pkg::num_banks],
	output shmem_pkg::bank_grant_t grant [shmem_pkg::num_banks],
	output logic [shmem_pkg::num_cores-1:0] wr_ack
);

	logic [shmem_pkg::num_cores-1:0] mask [shmem_pkg::num_banks];
	shmem_pkg::core_id_t last_core [shmem_pkg::num_banks];
	shmem_pkg::core_id_t next_core [shmem_pkg::num_banks];
	logic [shmem_pkg::num_banks-1:0] none_found;
	logic [shmem_pkg::num_banks-1:0] scan_hit;
	logic [shmem_pkg::num_banks-1:0] core_win;
	logic [shmem_pkg::num_cores-1:0] rd_issue;
	logic [shmem_pkg::num_cores-1:0] in_flight; // read granted last cycle, data due now
	shmem_pkg::bank_grant_t grant_d [shmem_pkg::num_banks];

	always_comb
	begin
		shmem_pkg::bank_id_t req_bank;
		for (int b = 0; b < shmem_pkg::num_banks; b++)
		begin
			for (int c = 0; c < shmem_pkg::num_cores; c++)
			begin
				req_bank = req[c].addr[shmem_pkg::addr_w-1:shmem_pkg::word_w];
				mask[b][c] = (req[c].op != shmem_pkg::op_none) &&
					(req_bank == shmem_pkg::bank_id_t'(b)) && !in_flight[c];
			end
		end
	end

	for (genvar b = 0; b < shmem_pkg::num_banks; b++)
	begin : g_finder
		rr_core_finder u_rr_core_finder
		(
			.mask(mask[b]),
			.last(last_core[b]),
			.next(next_core[b]),
			.none(none_found[b])
		);
	end

	always_comb
	begin
		shmem_pkg::core_req_t sel;
		logic sel_rd;
		logic sel_wr;
		wr_ack = '0;
		rd_issue = '0;
		for (int b = 0; b < shmem_pkg::num_banks; b++)
		begin
			sel = req[next_core[b]];
			scan_hit[b] = scan_req_valid &&
				(scan_req_addr[shmem_pkg::addr_w-1:shmem_pkg::word_w] == shmem_pkg::bank_id_t'(b));
			core_win[b] = !scan_hit[b] && !none_found[b]; // scan owns its bank outright
			sel_rd = core_win[b] && (sel.op == shmem_pkg::op_read);
			sel_wr = core_win[b] && (sel.op == shmem_pkg::op_write);

			bank_cmd[b].rd = scan_hit[b] || sel_rd;
			bank_cmd[b].wr = sel_wr;
			bank_cmd[b].addr = scan_hit[b] ? scan_req_addr[shmem_pkg::word_w-1:0]
				: sel.addr[shmem_pkg::word_w-1:0];
			bank_cmd[b].wdata = sel.wdata;

			grant_d[b].valid = scan_hit[b] || sel_rd;
			grant_d[b].is_scan = scan_hit[b];
			grant_d[b].core_id = next_core[b];

			if (sel_wr)
				wr_ack[next_core[b]] = 1'b1;
			if (sel_rd)
				rd_issue[next_core[b]] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			in_flight <= '0;
			for (int b = 0; b < shmem_pkg::num_banks; b++)
			begin
				grant[b] <= '0;
				last_core[b] <= '0;
			end
		end
		else
		begin
			in_flight <= rd_issue;
			for (int b = 0; b < shmem_pkg::num_banks; b++)
			begin
				grant[b] <= grant_d[b];
				if (core_win[b])
					last_core[b] <= next_core[b]; // scan cycles leave the pointer alone
			end
		end
	end

endmodule

//--- rtl/mem_bank.sv
`timescale 1ns/1ps

module mem_bank
(
	input logic clk,
	input shmem_pkg::word_addr_t addr,
	input shmem_pkg::data_t wdata,
	input logic rd,
	input logic wr,
	output shmem_pkg::data_t rdata
);

	shmem_pkg::data_t mem [shmem_pkg::bank_depth];

	always_ff @(posedge clk)
	begin
		if (wr)
			mem[addr] <= wdata;
		if (rd)
			rdata <= mem[addr]; // holds between reads
	end

endmodule

//--- rtl/scan_reader.sv
`timescale 1ns/1ps

module scan_reader
(
	input logic clk,
	input logic reset,
	input logic scan_start,
	input logic scan_blank,
	output logic req_valid,
	output shmem_pkg::addr_t req_addr,
	input shmem_pkg::data_t bank_data [shmem_pkg::num_banks],
	output shmem_pkg::scan_word_t scan_out,
	output logic scan_valid,
	output logic scan_done
);

	localparam shmem_pkg::addr_t last_addr = shmem_pkg::addr_t'(shmem_pkg::mem_words - 1);

	shmem_pkg::scan_state_e state;
	shmem_pkg::addr_t addr_cnt;
	shmem_pkg::addr_t prev_addr; // address whose data the banks return this cycle

	assign req_valid = (state == shmem_pkg::scan_run) && scan_blank;
	assign req_addr = addr_cnt;
	assign scan_done = (state == shmem_pkg::scan_idle);

	always_comb
	begin
		scan_out.addr = prev_addr;
		scan_out.data = bank_data[prev_addr[shmem_pkg::addr_w-1:shmem_pkg::word_w]];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= shmem_pkg::scan_idle;
			addr_cnt <= '0;
			scan_valid <= 1'b0;
		end
		else
		begin
			scan_valid <= req_valid;
			case (state)
				shmem_pkg::scan_idle:
				begin
					if (scan_start)
					begin
						state <= shmem_pkg::scan_run;
						addr_cnt <= '0;
					end
				end
				shmem_pkg::scan_run:
				begin
					// blanking low freezes the walk
					if (scan_blank)
					begin
						addr_cnt <= addr_cnt + shmem_pkg::addr_t'(1);
						if (addr_cnt == last_addr)
							state <= shmem_pkg::scan_drain;
					end
				end
				shmem_pkg::scan_drain:
					state <= shmem_pkg::scan_idle; // last word is on scan_out now
				default:
					state <= shmem_pkg::scan_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid)
			prev_addr <= req_addr;
	end

endmodule

//--- rtl/response_router.sv
`timescale 1ns/1ps

module response_router
(
	input shmem_pkg::bank_grant_t grant [shmem_pkg::num_banks],
	input shmem_pkg::data_t bank_data [shmem_pkg::num_banks],
	input logic [shmem_pkg::num_cores-1:0] wr_ack,
	output logic [shmem_pkg::num_cores-1:0] ready,
	output shmem_pkg::data_t rdata [shmem_pkg::num_cores]
);

	logic [shmem_pkg::num_cores-1:0] rd_done;

	// a core reads from at most one bank at a time, so one match at most
	always_comb
	begin
		logic hit;
		for (int c = 0; c < shmem_pkg::num_cores; c++)
		begin
			rd_done[c] = 1'b0;
			rdata[c] = '0;
			for (int b = 0; b < shmem_pkg::num_banks; b++)
			begin
				hit = grant[b].valid && !grant[b].is_scan &&
					(grant[b].core_id == shmem_pkg::core_id_t'(c));
				if (hit)
				begin
					rd_done[c] = 1'b1;
					rdata[c] = bank_data[b];
				end
			end
		end
	end

	assign ready = rd_done | wr_ack; // writes finish in the grant cycle

endmodule

//--- rtl/shared_mem.sv
`timescale 1ns/1ps

module shared_mem
(
	input logic clk,
	input logic reset,
	input shmem_pkg::core_req_t req [shmem_pkg::num_cores],
	output logic [shmem_pkg::num_cores-1:0] ready,
	output shmem_pkg::data_t rdata [shmem_pkg::num_cores],
	input logic scan_start,
	input logic scan_blank,
	output shmem_pkg::scan_word_t scan_out,
	output logic scan_valid,
	output logic scan_done
);

	shmem_pkg::bank_cmd_t bank_cmd [shmem_pkg::num_banks];
	shmem_pkg::bank_grant_t grant [shmem_pkg::num_banks];
	shmem_pkg::data_t bank_data [shmem_pkg::num_banks];
	logic [shmem_pkg::num_cores-1:0] wr_ack;
	logic scan_req_valid;
	shmem_pkg::addr_t scan_req_addr;

	bank_arbiter u_bank_arbiter
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.scan_req_valid(scan_req_valid),
		.scan_req_addr(scan_req_addr),
		.bank_cmd(bank_cmd),
		.grant(grant),
		.wr_ack(wr_ack)
	);

	for (genvar b = 0; b < shmem_pkg::num_banks; b++)
	begin : g_bank
		mem_bank u_mem_bank
		(
			.clk(clk),
			.addr(bank_cmd[b].addr),
			.wdata(bank_cmd[b].wdata),
			.rd(bank_cmd[b].rd),
			.wr(bank_cmd[b].wr),
			.rdata(bank_data[b])
		);
	end

	scan_reader u_scan_reader
	(
		.clk(clk),
		.reset(reset),
		.scan_start(scan_start),
		.scan_blank(scan_blank),
		.req_valid(scan_req_valid),
		.req_addr(scan_req_addr),
		.bank_data(bank_data),
		.scan_out(scan_out),
		.scan_valid(scan_valid),
		.scan_done(scan_done)
	);

	response_router u_response_router
	(
		.grant(grant),
		.bank_data(bank_data),
		.wr_ack(wr_ack),
		.ready(ready),
		.rdata(rdata)
	);

endmodule

//--- testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic report_error(input string msg);
	$display("ERROR at %0t: %s", $time, msg);
	error_count++;
endtask

task automatic check_data(input shmem_pkg::data_t got, input shmem_pkg::data_t exp,
	input string msg);
	if (got !== exp)
	begin
		$display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
		error_count++;
	end
endtask

task automatic check_scan(input shmem_pkg::scan_word_t got, input shmem_pkg::scan_word_t exp,
	input string msg);
	if (got !== exp)
	begin
		$display("MISMATCH at %0t: %s, got %h:%h expected %h:%h", $time, msg,
			got.addr, got.data, exp.addr, exp.data);
		error_count++;
	end
endtask

task automatic end_test(input string name, input int start);
	test_count++;
	if (error_count == start)
		$display("%s: ok", name);
	else
		$display("%s: %0d errors", name, error_count - start);
endtask

function automatic shmem_pkg::data_t fill_pattern(input shmem_pkg::addr_t a);
	return {a[5:0], a} ^ 16'h5a3c;
endfunction

task automatic draw_core_rand();
	for (int c = 0; c < shmem_pkg::num_cores; c++)
		for (int i = 0; i < rand_per_core; i++)
			core_rand[c][i] = rand_bits(32);
endtask

// entered and left 1 ns after a rising edge
// max_wait of 0 means no bound
task automatic core_access(input int c, input shmem_pkg::mem_op_e op, input shmem_pkg::addr_t addr,
	input shmem_pkg::data_t wdata, input int max_wait, input logic check_once);
	int waited;
	waited = 0;
	req[c].op = op;
	req[c].addr = addr;
	req[c].wdata = wdata;
	@(negedge clk);
	while (!ready[c] && waited < access_timeout)
	begin
		@(negedge clk);
		waited++;
	end
	if (!ready[c])
		report_error($sformatf("core %0d got no ready within %0d cycles", c, access_timeout));
	else
	begin
		if (max_wait > 0 && waited > max_wait)
			report_error($sformatf("core %0d waited %0d cycles for ready", c, waited));
		if (op == shmem_pkg::op_write)
			ref_mem[addr] = wdata;
		else
		begin
			if (waited == 0)
				report_error($sformatf("core %0d read ready came in its request cycle", c));
			check_data(rdata[c], ref_mem[addr], $sformatf("core %0d read of %h", c, addr));
		end
	end
	@(posedge clk);
	#1;
	req[c].op = shmem_pkg::op_none;
	if (check_once)
	begin
		@(negedge clk);
		if (ready[c])
			report_error($sformatf("core %0d was served twice for one request", c));
		@(posedge clk);
		#1;
	end
endtask

task automatic start_scan();
	scan_pos = 0;
	scan_start = 1'b1;
	@(posedge clk);
	#1;
	scan_start = 1'b0;
endtask

task automatic capture_scan();
	shmem_pkg::scan_word_t exp;
	int idle;
	logic blank_before; // scan_blank in the cycle before
	idle = 0;
	blank_before = 1'b1;
	while (scan_pos < shmem_pkg::mem_words && idle < scan_idle_limit)
	begin
		@(negedge clk);
		if (scan_valid)
		begin
			if (!blank_before)
				report_error("a scan word came out after a cycle with blanking low");
			exp.addr = shmem_pkg::addr_t'(scan_pos);
			exp.data = ref_mem[scan_pos];
			check_scan(scan_out, exp, $sformatf("scan word %0d", scan_pos));
			if (scan_done)
				report_error("scan_done was high while words were still coming out");
			scan_pos++;
			idle = 0;
		end
		else
			idle++;
		blank_before = scan_blank;
	end
	if (scan_pos < shmem_pkg::mem_words)
		report_error($sformatf("scan stalled after %0d words", scan_pos));
	else
	begin
		@(negedge clk);
		if (!scan_done)
			report_error("scan_done did not rise the cycle after the last word");
	end
endtask

task automatic fill_bank(input int c);
	shmem_pkg::addr_t a;
	for (int w = 0; w < shmem_pkg::bank_depth; w++)
	begin
		a = {shmem_pkg::bank_id_t'(c), shmem_pkg::word_addr_t'(w)};
		core_access(c, shmem_pkg::op_write, a, fill_pattern(a), 0, 1'b0);
	end
endtask

// low address bits carry the core number so cores never share a word
task automatic conflict_core(input int c, input shmem_pkg::bank_id_t bank);
	shmem_pkg::addr_t a;
	a = {bank, core_rand[c][0][7:2], shmem_pkg::core_id_t'(c)};
	core_access(c, shmem_pkg::op_write, a, core_rand[c][1][15:0], shmem_pkg::num_cores, 1'b1);
	core_access(c, shmem_pkg::op_read, a, '0, shmem_pkg::num_cores, 1'b1);
endtask

task automatic parallel_core(input int c);
	shmem_pkg::addr_t a;
	a = {shmem_pkg::bank_id_t'(c), core_rand[c][0][7:0]};
	core_access(c, shmem_pkg::op_write, a, core_rand[c][1][15:0], 1, 1'b0);
	core_access(c, shmem_pkg::op_read, a, '0, 1, 1'b0);
endtask

task automatic traffic_core(input int c);
	int r;
	shmem_pkg::addr_t a;
	while (scan_pos < 64)
	begin
		@(posedge clk);
		#1;
	end
	for (int i = 0; i < rand_per_core / 2; i++)
	begin
		r = int'(core_rand[c][2 * i][15:0]) % (scan_pos - 4); // behind the scan
		a = shmem_pkg::addr_t'((r & ~3) | c);
		core_access(c, shmem_pkg::op_write, a, core_rand[c][2 * i + 1][15:0], 0, 1'b0);
		core_access(c, shmem_pkg::op_read, a, '0, 0, 1'b0);
	end
endtask

task automatic check_reset_state();
	int start;
	start = error_count;
	@(negedge clk);
	if (ready !== '0)
		report_error("ready is not low after reset");
	if (scan_valid !== 1'b0)
		report_error("scan_valid is not low after reset");
	if (scan_done !== 1'b1)
		report_error("scan_done is not high after reset");
	@(posedge clk);
	#1;
	end_test("reset state", start);
endtask

task automatic fill_memory();
	int start;
	start = error_count;
	fork
		fill_bank(0);
		fill_bank(1);
		fill_bank(2);
		fill_bank(3);
	join
	end_test("memory fill", start);
endtask

task automatic single_core_rw();
	shmem_pkg::addr_t addrs [single_ops];
	int start;
	start = error_count;
	for (int i = 0; i < single_ops; i++)
	begin
		addrs[i] = shmem_pkg::addr_t'(rand_bits(shmem_pkg::addr_w));
		core_access(0, shmem_pkg::op_write, addrs[i],
			shmem_pkg::data_t'(rand_bits(shmem_pkg::data_w)), 0, 1'b0);
	end
	for (int i = 0; i < single_ops; i++)
		core_access(0, shmem_pkg::op_read, addrs[i], '0, 1, 1'b0);
	end_test("single core write and read", start);
endtask

task automatic bank_conflict();
	shmem_pkg::bank_id_t bank;
	int start;
	start = error_count;
	bank = shmem_pkg::bank_id_t'(rand_bits(shmem_pkg::bank_w));
	draw_core_rand();
	fork
		conflict_core(0, bank);
		conflict_core(1, bank);
		conflict_core(2, bank);
		conflict_core(3, bank);
	join
	end_test("bank conflict", start);
endtask

task automatic parallel_banks();
	int start;
	start = error_count;
	draw_core_rand();
	fork
		parallel_core(0);
		parallel_core(1);
		parallel_core(2);
		parallel_core(3);
	join
	end_test("parallel banks", start);
endtask

task automatic scan_copy();
	int start;
	start = error_count;
	blank_random = 1'b1;
	start_scan();
	capture_scan();
	blank_random = 1'b0;
	@(posedge clk);
	#1;
	end_test("scan copy", start);
endtask

task automatic scan_with_traffic();
	int start;
	start = error_count;
	draw_core_rand();
	blank_random = 1'b1;
	start_scan();
	fork
		capture_scan();
		traffic_core(0);
		traffic_core(1);
		traffic_core(2);
		traffic_core(3);
	join
	blank_random = 1'b0;
	@(posedge clk);
	#1;
	end_test("scan with core traffic", start);
endtask

`endif

//--- testbench/tb_shared_mem.sv
`timescale 1ns/1ps

module tb_shared_mem;

	localparam int clk_period = 20;
	localparam int reset_cycles = 10;
	localparam int access_timeout = 3000; // cycles one core may wait for ready
	localparam int scan_idle_limit = 64;
	localparam int single_ops = 16;
	localparam int rand_per_core = 12;
	// rough length of all tests in cycles, scans run at about half rate
	localparam int test_cycles = reset_cycles + 2 * shmem_pkg::bank_depth + 6 * single_ops + 80
		+ 6 * shmem_pkg::mem_words;
	localparam int watchdog_margin = 3;

	logic clk;
	logic reset;
	shmem_pkg::core_req_t req [shmem_pkg::num_cores];
	logic [shmem_pkg::num_cores-1:0] ready;
	shmem_pkg::data_t rdata [shmem_pkg::num_cores];
	logic scan_start;
	logic scan_blank;
	shmem_pkg::scan_word_t scan_out;
	logic scan_valid;
	logic scan_done;

	shmem_pkg::data_t ref_mem [shmem_pkg::mem_words]; // expected memory contents
	logic [31:0] core_rand [shmem_pkg::num_cores][rand_per_core];
	logic [31:0] lfsr_state;
	logic [31:0] blank_state;
	logic blank_random;
	int scan_pos; // words presented so far by the running scan
	int error_count;
	int test_count;

	shared_mem u_shared_mem
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.ready(ready),
		.rdata(rdata),
		.scan_start(scan_start),
		.scan_blank(scan_blank),
		.scan_out(scan_out),
		.scan_valid(scan_valid),
		.scan_done(scan_done)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	`include "tb_checks.svh"

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// blanking stream has its own LFSR so it does not race the test processes
	initial
	begin
		scan_blank = 1'b1;
		blank_state = 32'h484e;
		forever
		begin
			@(posedge clk);
			#1;
			if (blank_random)
			begin
				blank_state = lfsr_next(blank_state);
				scan_blank = blank_state[0];
			end
			else
				scan_blank = 1'b1;
		end
	end

	initial
	begin
		#(test_cycles * watchdog_margin * clk_period);
		$display("timeout: the tests did not finish within %0d cycles",
			test_cycles * watchdog_margin);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		scan_start = 1'b0;
		blank_random = 1'b0;
		lfsr_state = 32'h484e;
		scan_pos = 0;
		error_count = 0;
		test_count = 0;
		for (int c = 0; c < shmem_pkg::num_cores; c++)
			req[c] = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;

		check_reset_state();
		fill_memory();
		single_core_rw();
		bank_conflict();
		parallel_banks();
		scan_copy();
		scan_with_traffic();

		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- src.f
+incdir+testbench
rtl/shmem_pkg.sv
rtl/rr_core_finder.sv
rtl/bank_arbiter.sv
rtl/mem_bank.sv
rtl/scan_reader.sv
rtl/response_router.sv
rtl/shared_mem.sv
testbench/tb_shared_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_shared_mem -f src.f -o sim_tb \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }

grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
